//--- compile.f
verilog/rcn_pkg.sv
verilog/rcn_master.sv
verilog/rcn_event.sv
verilog/rcn_scratch.sv
verilog/rcn_event_top.sv
verif/rcn_event_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module rcn_event_tb \
  && ./obj_dir/Vrcn_event_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verif/rcn_event_tb.sv
`timescale 1ns/1ps
// ######################################################################
// Random ring requests checked against a model of flags, masks and words
// Uses the default address map of rcn_event_top, one request at a time
// ######################################################################
module rcn_event_tb
  import rcn_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_OPS        = 400;

  logic        CLK;
  logic        RST;
  logic        req_valid;
  logic        req_write;
  logic        req_posted;
  rcn_addr_t   req_addr;
  logic [31:0] req_data;
  logic        busy;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        rsp_err;
  logic [3:0]  event_pending;

  // Reference model of the slave state
  logic [31:0] model_flags [4];
  logic [31:0] model_masks [4];
  logic [31:0] model_words [8];

  integer      seed;
  int          errors;
  int          checks;
  logic        timed_out;
  logic [31:0] rnd;
  logic [31:0] rnd2;
  logic [7:0]  kind;

  rcn_event_top rcn_event_top_inst (
    .CLK(CLK), .RST(RST),
    .req_valid(req_valid), .req_write(req_write), .req_posted(req_posted),
    .req_addr(req_addr), .req_data(req_data),
    .busy(busy), .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_err(rsp_err),
    .event_pending(event_pending)
  );

  initial
  begin
    CLK = 1'b0;
    forever
      #10 CLK = ~CLK;
  end

  // Per register, any set flag whose mask bit is clear
  function automatic logic [3:0] expected_pending();
    logic [3:0] p;
    for (int i = 0; i < 4; i++)
      p[i] = |(model_flags[i] & ~model_masks[i]);
    return p;
  endfunction

  // Mostly valid bit numbers, some just out of range, some large
  function automatic logic [31:0] pick_event_value(input logic [31:0] r, input logic [31:0] r2);
    case (r[7:6])
      2'b11:   return r2;
      2'b10:   return 32'd32 + {27'd0, r2[4:0]};
      default: return {27'd0, r2[4:0]};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // One-cycle strobe, driven just after the rising edge
  task automatic send_request(input logic write, input logic posted,
                              input rcn_addr_t addr, input logic [31:0] data);
    @(posedge CLK);
    #1;
    req_valid  = 1'b1;
    req_write  = write;
    req_posted = posted;
    req_addr   = addr;
    req_data   = data;
    @(posedge CLK);
    #1;
    req_valid  = 1'b0;
  endtask

  // Pending is already settled when the response reaches the master
  task automatic wait_response(input logic [31:0] exp_data, input logic exp_err);
    int cycles;
    cycles = 0;
    while (rsp_valid !== 1'b1 && cycles < TIMEOUT_CYCLES)
    begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    if (rsp_valid !== 1'b1)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout at %0t: no rsp_valid within %0d cycles", $time, TIMEOUT_CYCLES);
    end
    else
    begin
      check_value("rsp_err", 32'(exp_err), 32'(rsp_err));
      check_value("rsp_data", exp_data, rsp_data);
      check_value("event_pending", 32'(expected_pending()), 32'(event_pending));
      // busy drops on the same edge that raises rsp_valid
      check_value("busy", 32'd0, 32'(busy));
    end
  endtask

  // A posted write must drop busy without ever raising rsp_valid
  task automatic wait_posted_done();
    int cycles;
    cycles = 0;
    while (busy === 1'b1 && cycles < TIMEOUT_CYCLES)
    begin
      @(posedge CLK);
      #1;
      cycles++;
      if (rsp_valid === 1'b1)
      begin
        errors++;
        $display("Unexpected rsp_valid at %0t for a posted write", $time);
      end
    end
    if (busy !== 1'b0)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout at %0t: busy stayed high after a posted write", $time);
    end
  endtask

  task automatic write_flag(input logic [1:0] sel, input logic [31:0] value,
                            input logic posted);
    logic [31:0] expected;
    expected = model_flags[sel];
    if (value < 32'd32)
      model_flags[sel] = model_flags[sel] | (32'd1 << value[4:0]);
    send_request(1'b1, posted, {15'h7FFF, 1'b0, sel}, value);
    if (posted)
      wait_posted_done();
    else
      wait_response(expected, 1'b0);
  endtask

  // Read returns the flags and clears them
  task automatic read_flag(input logic [1:0] sel);
    logic [31:0] expected;
    expected = model_flags[sel];
    model_flags[sel] = 32'd0;
    send_request(1'b0, 1'b0, {15'h7FFF, 1'b0, sel}, 32'd0);
    wait_response(expected, 1'b0);
  endtask

  task automatic access_mask(input logic [1:0] sel, input logic write, input logic [31:0] data);
    logic [31:0] expected;
    expected = model_masks[sel];
    if (write)
      model_masks[sel] = data;
    send_request(write, 1'b0, {15'h7FFF, 1'b1, sel}, data);
    wait_response(expected, 1'b0);
  endtask

  // A scratch write answers with the written value
  task automatic access_scratch(input logic [2:0] sel, input logic write, input logic [31:0] data);
    logic [31:0] expected;
    if (write)
      model_words[sel] = data;
    expected = model_words[sel];
    send_request(write, 1'b0, {15'h0008, sel}, data);
    wait_response(expected, 1'b0);
  endtask

  // Nobody claims it, so it returns as a request and flags an error
  task automatic access_unclaimed(input rcn_addr_t addr, input logic write,
                                  input logic [31:0] data);
    send_request(write, 1'b0, addr, data);
    wait_response(32'd0, 1'b1);
  endtask

  initial
  begin
    RST        = 1'b1;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_posted = 1'b0;
    req_addr   = '0;
    req_data   = 32'd0;
    seed       = 90;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      model_flags[i] = 32'd0;
      model_masks[i] = 32'd0;
    end
    for (int i = 0; i < 8; i++)
      model_words[i] = 32'd0;

    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
    check_value("busy", 32'd0, 32'(busy));
    check_value("rsp_valid", 32'd0, 32'(rsp_valid));
    check_value("event_pending", 32'd0, 32'(event_pending));

    // Set, read-clear, then read again for zero
    write_flag(2'd0, 32'd5, 1'b0);
    read_flag(2'd0);
    read_flag(2'd0);
    // Bit number 40 is out of range and changes nothing
    write_flag(2'd1, 32'd40, 1'b0);
    read_flag(2'd1);

    for (int n = 0; n < NUM_OPS && !timed_out; n++)
    begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      kind = rnd[15:8] % 8'd10;
      case (kind)
        8'd0, 8'd1, 8'd2: write_flag(rnd[1:0], pick_event_value(rnd, rnd2), 1'b0);
        8'd3, 8'd4:       read_flag(rnd[1:0]);
        8'd5:             access_mask(rnd[1:0], rnd[16], rnd2);
        8'd6, 8'd7:       access_scratch(rnd[2:0], rnd[16], rnd2);
        8'd8:             access_unclaimed({7'h01, rnd[26:16]}, rnd[27], rnd2);
        default:          write_flag(rnd[1:0], pick_event_value(rnd, rnd2), 1'b1);
      endcase
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- verilog/rcn_event.sv
`timescale 1ns/1ps
// ####################################################################
// Event-flag slave, four flag words and four mask words on the ring
// Partial write masks are claimed and answered but change nothing
// Fixed three-cycle delay from rcn_in to rcn_out for every flit
// ####################################################################
module rcn_event
  import rcn_pkg::*;
#(
  parameter logic [19:0] EVENT_ADDR_MASK = 20'hFFFE0,
  parameter logic [19:0] EVENT_ADDR_BASE = 20'hFFFE0
)
(
  input  logic       CLK,
  input  logic       RST,
  output logic [3:0] event_pending,
  input  rcn_flit_t  rcn_in,
  output rcn_flit_t  rcn_out
);

  // Input register, match stage and output register
  rcn_flit_t din;
  rcn_flit_t din_d1;
  logic      match;
  logic      match_d1;

  // Flag and mask state, indexed by the low 2 bits of the word address
  logic [3:0][31:0] flags;
  logic [3:0][31:0] masks;

  // Register contents before the claimed operation
  logic [31:0] rd_data;

  logic [1:0]  sel;
  logic        sel_mask;
  logic        is_write;
  logic        is_read;
  logic [31:0] set_bit;
  rcn_flit_t   rsp_flit;

  always_comb
  begin
    match    = din.valid && din.req &&
               rcn_addr_hit(din.addr, EVENT_ADDR_BASE, EVENT_ADDR_MASK);
    // Word 0 to 3 are flags, 4 to 7 are masks
    sel      = din.addr[1:0];
    sel_mask = din.addr[2];
    is_write = (din.wmask == RCN_WMASK_WRITE);
    is_read  = (din.wmask == RCN_WMASK_READ);
    // Bit numbers of 32 and above set no flag
    if (din.data < 32'd32)
      set_bit = 32'd1 << din.data[4:0];
    else
      set_bit = 32'd0;
  end

  always_comb
  begin
    // Response keeps ID and address so it finds its way home
    rsp_flit      = din_d1;
    rsp_flit.req  = 1'b0;
    rsp_flit.data = rd_data;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      din      <= RCN_FLIT_IDLE;
      din_d1   <= RCN_FLIT_IDLE;
      match_d1 <= 1'b0;
      rcn_out  <= RCN_FLIT_IDLE;
    end
    else
    begin
      din      <= rcn_in;
      din_d1   <= din;
      match_d1 <= match;
      if (!match_d1)
        rcn_out <= din_d1;
      else if (din_d1.src_id == RCN_ID_POSTED)
        rcn_out <= RCN_FLIT_IDLE;
      else
        rcn_out <= rsp_flit;
    end
  end

  // State changes at the match stage, two cycles ahead of the response
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      flags <= '0;
      masks <= '0;
    end
    else if (match)
    begin
      if (sel_mask)
      begin
        if (is_write)
          masks[sel] <= din.data;
      end
      else if (is_write)
      begin
        flags[sel] <= flags[sel] | set_bit;
      end
      else if (is_read)
      begin
        // Reading a flag word clears it
        flags[sel] <= 32'd0;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (match)
      rd_data <= sel_mask ? masks[sel] : flags[sel];
  end

  // Pending follows the state one cycle later
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      event_pending <= 4'd0;
    else
      for (int i = 0; i < 4; i++)
        event_pending[i] <= |(flags[i] & ~masks[i]);
  end

  // A claimed flit entered on rcn_in as a request three cycles earlier
  // Unless posted it leaves as the response to the same master and address
  a_claim_answered: assert property (@(posedge CLK) disable iff (RST)
    (match_d1 && (din_d1.src_id != RCN_ID_POSTED)) |=>
      ($past(rcn_in.valid && rcn_in.req, 3) &&
       rcn_out.valid && !rcn_out.req &&
       (rcn_out.src_id == $past(rcn_in.src_id, 3)) &&
       (rcn_out.addr == $past(rcn_in.addr, 3))));

endmodule

//--- verilog/rcn_event_top.sv
`timescale 1ns/1ps
// ####################################################################
// Ring of one master, the event slave and the scratch slave
// One request at a time, req_valid only while busy is low
// ####################################################################
module rcn_event_top
  import rcn_pkg::*;
#(
  parameter rcn_id_t     MASTER_ID         = 8'h01,
  parameter logic [19:0] EVENT_ADDR_BASE   = 20'hFFFE0,
  parameter logic [19:0] EVENT_ADDR_MASK   = 20'hFFFE0,
  parameter logic [19:0] SCRATCH_ADDR_BASE = 20'h00100
)
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        req_valid,
  input  logic        req_write,
  input  logic        req_posted,
  input  rcn_addr_t   req_addr,
  input  logic [31:0] req_data,
  output logic        busy,
  output logic        rsp_valid,
  output logic [31:0] rsp_data,
  output logic        rsp_err,
  output logic [3:0]  event_pending
);

  // Ring links, each driven by a register in its source module
  rcn_flit_t master_to_event;
  rcn_flit_t event_to_scratch;
  rcn_flit_t scratch_to_master;

  rcn_master #(.MASTER_ID(MASTER_ID)) rcn_master_inst (
    .CLK(CLK), .RST(RST),
    .req_valid(req_valid), .req_write(req_write), .req_posted(req_posted),
    .req_addr(req_addr), .req_data(req_data),
    .busy(busy), .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_err(rsp_err),
    .rcn_in(scratch_to_master), .rcn_out(master_to_event)
  );

  rcn_event #(.EVENT_ADDR_MASK(EVENT_ADDR_MASK), .EVENT_ADDR_BASE(EVENT_ADDR_BASE))
    rcn_event_inst (
    .CLK(CLK), .RST(RST), .event_pending(event_pending),
    .rcn_in(master_to_event), .rcn_out(event_to_scratch)
  );

  rcn_scratch #(.SCRATCH_ADDR_BASE(SCRATCH_ADDR_BASE)) rcn_scratch_inst (
    .CLK(CLK), .RST(RST),
    .rcn_in(event_to_scratch), .rcn_out(scratch_to_master)
  );

endmodule

//--- verilog/rcn_master.sv
`timescale 1ns/1ps
// ####################################################################
// Single ring master with at most one request in flight
// Posted writes use ID 0xFF and release busy once the flit is sent
// A returning request with ID 0xFF was unclaimed and is dropped quietly
// ####################################################################
module rcn_master
  import rcn_pkg::*;
#(
  parameter rcn_id_t MASTER_ID = 8'h01
)
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        req_valid,
  input  logic        req_write,
  input  logic        req_posted,
  input  rcn_addr_t   req_addr,
  input  logic [31:0] req_data,
  output logic        busy,
  output logic        rsp_valid,
  output logic [31:0] rsp_data,
  output logic        rsp_err,
  input  rcn_flit_t   rcn_in,
  output rcn_flit_t   rcn_out
);

  // Request flit held until an empty slot comes by
  rcn_flit_t req_flit;
  // High while req_flit still has to go onto the ring
  logic      pend;
  logic      accept;
  logic      own_hit;
  logic      orphan_hit;
  logic      insert;

  always_comb
  begin
    accept     = req_valid && !busy;
    // Our own flit came back, either answered or still a request
    own_hit    = rcn_in.valid && (rcn_in.src_id == MASTER_ID);
    // A posted write that no slave claimed, and only this master sends those
    orphan_hit = rcn_in.valid && rcn_in.req && (rcn_in.src_id == RCN_ID_POSTED);
    // Slot rule: only an empty slot may be filled
    insert     = pend && !rcn_in.valid;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rcn_out   <= RCN_FLIT_IDLE;
      pend      <= 1'b0;
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end
    else
    begin
      rsp_valid <= own_hit;
      // A flit that is still a request went all the way round unclaimed
      rsp_err   <= own_hit && rcn_in.req;

      // The output register is the only stage between rcn_in and rcn_out
      if (own_hit || orphan_hit)
        rcn_out <= RCN_FLIT_IDLE;
      else if (insert)
        rcn_out <= req_flit;
      else
        rcn_out <= rcn_in;

      if (accept)
      begin
        busy <= 1'b1;
        pend <= 1'b1;
      end
      else if (insert)
      begin
        pend <= 1'b0;
        // Nothing comes back for a posted write
        if (req_flit.src_id == RCN_ID_POSTED)
          busy <= 1'b0;
      end
      else if (own_hit)
      begin
        busy <= 1'b0;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      req_flit.valid  <= 1'b1;
      req_flit.req    <= 1'b1;
      req_flit.src_id <= req_posted ? RCN_ID_POSTED : MASTER_ID;
      req_flit.wmask  <= req_write ? RCN_WMASK_WRITE : RCN_WMASK_READ;
      req_flit.addr   <= req_addr;
      req_flit.data   <= req_data;
    end
    if (own_hit)
      rsp_data <= rcn_in.req ? 32'd0 : rcn_in.data;
  end

  // The caller must wait for busy to fall before the next strobe
  a_no_req_while_busy: assert property (@(posedge CLK) disable iff (RST)
    req_valid |-> !busy);

  // A posted read would never be answered
  a_posted_is_write: assert property (@(posedge CLK) disable iff (RST)
    (req_valid && req_posted) |-> req_write);

endmodule

//--- verilog/rcn_pkg.sv
// ####################################################################
// Shared ring flit layout, ID values and address decode for the ring
// Addresses on the ring are word addresses, and ranges are byte values
// ####################################################################
package rcn_pkg;

  // Word address carried in a flit, byte address divided by 4
  typedef logic [17:0] rcn_addr_t;

  // Master ID, also used to route responses back
  typedef logic [7:0] rcn_id_t;

  // One 64-bit ring slot, fields listed from the top bit down
  typedef struct packed {
    logic      valid;
    logic      req;
    rcn_id_t   src_id;
    logic [3:0] wmask;
    rcn_addr_t addr;
    logic [31:0] data;
  } rcn_flit_t;

  // Requests with this ID are taken off the ring without a response
  localparam rcn_id_t RCN_ID_POSTED = 8'hFF;

  // Only full writes and plain reads are decoded by the slaves
  localparam logic [3:0] RCN_WMASK_WRITE = 4'b1111;
  localparam logic [3:0] RCN_WMASK_READ  = 4'b0000;

  // An empty slot
  localparam rcn_flit_t RCN_FLIT_IDLE = '0;

  // True when the word address falls in the byte range given by base and mask
  function automatic logic rcn_addr_hit(
    input rcn_addr_t   addr,
    input logic [19:0] base,
    input logic [19:0] mask
  );
    return (({addr, 2'b00} & mask) == (base & mask));
  endfunction

endpackage

//--- verilog/rcn_scratch.sv
`timescale 1ns/1ps
// ####################################################################
// Eight-word scratch register slave, base aligned to 32 bytes
// Partial write masks read the word and leave it unchanged
// ####################################################################
module rcn_scratch
  import rcn_pkg::*;
#(
  parameter logic [19:0] SCRATCH_ADDR_BASE = 20'h00100
)
(
  input  logic      CLK,
  input  logic      RST,
  input  rcn_flit_t rcn_in,
  output rcn_flit_t rcn_out
);

  // Eight words cover 32 bytes of byte address space
  localparam logic [19:0] SCRATCH_ADDR_MASK = 20'hFFFE0;

  rcn_flit_t        din;
  rcn_flit_t        din_d1;
  logic             match;
  logic             match_d1;
  logic [7:0][31:0] words;
  logic [31:0]      rd_data;
  logic             is_write;

  always_comb
  begin
    match    = din.valid && din.req &&
               rcn_addr_hit(din.addr, SCRATCH_ADDR_BASE, SCRATCH_ADDR_MASK);
    is_write = (din.wmask == RCN_WMASK_WRITE);
  end

  // Same three stages as the event slave
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      din      <= RCN_FLIT_IDLE;
      din_d1   <= RCN_FLIT_IDLE;
      match_d1 <= 1'b0;
      rcn_out  <= RCN_FLIT_IDLE;
      words    <= '0;
    end
    else
    begin
      din      <= rcn_in;
      din_d1   <= din;
      match_d1 <= match;
      if (match && is_write)
        words[din.addr[2:0]] <= din.data;
      if (!match_d1)
        rcn_out <= din_d1;
      else if (din_d1.src_id == RCN_ID_POSTED)
        rcn_out <= RCN_FLIT_IDLE;
      else
        rcn_out <= '{valid: 1'b1, req: 1'b0, src_id: din_d1.src_id,
                     wmask: din_d1.wmask, addr: din_d1.addr, data: rd_data};
    end
  end

  // A write answers with the value written
  always_ff @(posedge CLK)
  begin
    if (match)
      rd_data <= is_write ? din.data : words[din.addr[2:0]];
  end

endmodule
